/* eye_tracker.f */
source/video_pkg.sv
source/report_pkg.sv
source/camera_capture.sv
source/frame_store.sv
source/gravity_calc.sv
source/uart_report.sv
source/eye_tracker_top.sv
verif/tb_eye_tracker.sv

/* run_sim.sh */
#!/bin/sh
# Compile the eye tracker testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_eye_tracker \
    -f eye_tracker.f -o sim_eye_tracker \
  && ./obj_dir/sim_eye_tracker | tee /dev/stderr | grep -q "All tests passed!" \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }

/* source/camera_capture.sv */
/*
 * Camera input stage
 *   input registers, pixel thresholding, line packing,
 *   line write strobes and frame end pulse
 */
module camera_capture (
    input  logic              cclk,
    input  logic              rst,
    input  logic              fval,
    input  logic              lval,
    input  logic              dval,
    input  video_pkg::pixel_t data,
    input  video_pkg::pixel_t threshold,
    output logic              wr_en,
    output video_pkg::row_t   wr_row,
    output video_pkg::line_t  wr_line,
    output logic              frame_done
);
    import video_pkg::*;

    logic       fval_q;
    logic       lval_q;
    logic       dval_q;
    logic       fval_d;
    logic       lval_d;
    pixel_t     data_q;
    pixel_t     threshold_q;
    logic       pix_valid;
    logic       line_end;
    logic       frame_end;
    x_t         pix_cnt;
    logic       line_full;
    line_t      line_buf;
    row_t       row_cnt;
    cap_state_t state;

    // --------------------------------------------------
    // Input registers and edge detection
    // --------------------------------------------------
    always_ff @(posedge cclk) begin
        if (rst) begin
            fval_q <= 1'b0;
            lval_q <= 1'b0;
            dval_q <= 1'b0;
            fval_d <= 1'b0;
            lval_d <= 1'b0;
        end else begin
            fval_q <= fval;
            lval_q <= lval;
            dval_q <= dval;
            fval_d <= fval_q;
            lval_d <= lval_q;
        end
    end

    always_ff @(posedge cclk) begin
        data_q      <= data;
        threshold_q <= threshold;
    end

    assign pix_valid = fval_q & lval_q & dval_q & ~line_full;
    assign line_end  = lval_d & ~lval_q;
    assign frame_end = fval_d & ~fval_q;

    // --------------------------------------------------
    // Line packing with one bit per pixel
    // --------------------------------------------------
    always_ff @(posedge cclk) begin
        if (rst || line_end) begin
            pix_cnt   <= '0;
            line_full <= 1'b0;
            line_buf  <= '0;
        end else if (pix_valid) begin
            pix_cnt            <= pix_cnt + 1'b1;   // Wraps after the last pixel
            line_full          <= (pix_cnt == x_t'(LINE_PIXELS - 1));
            line_buf[pix_cnt]  <= (data_q >= threshold_q);
        end
    end

    // Row sequencing per frame
    always_ff @(posedge cclk) begin
        if (rst) begin
            state      <= CAP_IDLE;
            row_cnt    <= '0;
            wr_en      <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            wr_en      <= 1'b0;
            frame_done <= frame_end;
            case (state)
                CAP_IDLE: begin
                    if (fval_q) state <= CAP_FRAME;
                end
                CAP_FRAME: begin
                    if (line_end && fval_q) begin
                        wr_en   <= 1'b1;
                        row_cnt <= row_cnt + 1'b1;
                        if (row_cnt == row_t'(FRAME_LINES - 1)) state <= CAP_FULL;
                    end
                end
                default: ;                          // CAP_FULL waits for frame end
            endcase
            if (frame_end) begin
                state   <= CAP_IDLE;
                row_cnt <= '0;
            end
        end
    end

    always_ff @(posedge cclk) begin
        if (line_end) begin
            wr_row  <= row_cnt;
            wr_line <= line_buf;
        end
    end

endmodule

/* source/eye_tracker_top.sv */
/*
 * Eye tracker top level
 *   capture, frame store, gravity calculator and UART reporter
 */
module eye_tracker_top (
    input  logic              cclk,
    input  logic              rst,
    input  logic              fval,
    input  logic              lval,
    input  logic              dval,
    input  video_pkg::pixel_t data,
    input  video_pkg::pixel_t threshold,
    output logic              uart_txd
);
    import video_pkg::*;
    import report_pkg::*;

    // Capture to store
    logic    wr_en;
    row_t    wr_row;
    line_t   wr_line;
    logic    frame_done;

    // Store to calculator
    row_t    rd_row;
    line_t   rd_line;

    // Calculator to reporter
    logic    report_start;
    logic    report_busy;
    sum_s_t  sum_s;
    sum_sx_t sum_sx;
    sum_sy_t sum_sy;

    // --------------------------------------------------
    // Measurement path
    // --------------------------------------------------
    camera_capture m_capture (
        .cclk(cclk), .rst(rst),
        .fval(fval), .lval(lval), .dval(dval),
        .data(data), .threshold(threshold),
        .wr_en(wr_en), .wr_row(wr_row), .wr_line(wr_line),
        .frame_done(frame_done)
    );

    frame_store m_store (
        .cclk(cclk), .rst(rst), .frame_done(frame_done),
        .wr_en(wr_en), .wr_row(wr_row), .wr_line(wr_line),
        .rd_row(rd_row), .rd_line(rd_line)
    );

    gravity_calc m_gravity (
        .cclk(cclk), .rst(rst),
        .frame_done(frame_done), .report_busy(report_busy),
        .rd_row(rd_row), .rd_line(rd_line),
        .report_start(report_start),
        .sum_s(sum_s), .sum_sx(sum_sx), .sum_sy(sum_sy)
    );

    uart_report m_report (
        .cclk(cclk), .rst(rst), .report_start(report_start),
        .sum_s(sum_s), .sum_sx(sum_sx), .sum_sy(sum_sy),
        .report_busy(report_busy), .uart_txd(uart_txd)
    );

endmodule

/* source/frame_store.sv */
/*
 * Two-bank binary frame store
 *   one line per word, bank swap on frame end,
 *   per-row valid flags so an unwritten row reads as empty
 */
module frame_store (
    input  logic             cclk,
    input  logic             rst,
    input  logic             frame_done,
    input  logic             wr_en,
    input  video_pkg::row_t  wr_row,
    input  video_pkg::line_t wr_line,
    input  video_pkg::row_t  rd_row,
    output video_pkg::line_t rd_line
);
    import video_pkg::*;

    line_t                  bank0 [FRAME_LINES];
    line_t                  bank1 [FRAME_LINES];
    logic [FRAME_LINES-1:0] valid0;
    logic [FRAME_LINES-1:0] valid1;
    logic                   wr_bank;                // Bank being filled by capture

    always_ff @(posedge cclk) begin
        if (wr_en && !wr_bank) bank0[wr_row] <= wr_line;
        if (wr_en &&  wr_bank) bank1[wr_row] <= wr_line;
    end

    // --------------------------------------------------
    // Bank select and row valid flags
    // --------------------------------------------------
    always_ff @(posedge cclk) begin
        if (rst) begin
            wr_bank <= 1'b0;
            valid0  <= '0;
            valid1  <= '0;
        end else begin
            if (wr_en && !wr_bank) valid0[wr_row] <= 1'b1;
            if (wr_en &&  wr_bank) valid1[wr_row] <= 1'b1;
            if (frame_done) begin
                wr_bank <= ~wr_bank;
                // Bank that becomes the write bank starts empty
                if (wr_bank) valid0 <= '0;
                else         valid1 <= '0;
            end
        end
    end

    // Registered read from the finished bank
    always_ff @(posedge cclk) begin
        if (wr_bank) rd_line <= valid0[rd_row] ? bank0[rd_row] : '0;
        else         rd_line <= valid1[rd_row] ? bank1[rd_row] : '0;
    end

endmodule

/* source/gravity_calc.sv */
/*
 * Gravity calculator
 *   reads the finished bank line by line and forms
 *   pixel count, x position sum and y position sum
 */
module gravity_calc (
    input  logic               cclk,
    input  logic               rst,
    input  logic               frame_done,
    input  logic               report_busy,
    output video_pkg::row_t    rd_row,
    input  video_pkg::line_t   rd_line,
    output logic               report_start,
    output report_pkg::sum_s_t  sum_s,
    output report_pkg::sum_sx_t sum_sx,
    output report_pkg::sum_sy_t sum_sy
);
    import video_pkg::*;
    import report_pkg::*;

    grav_state_t state;
    logic        line_valid;                        // rd_line holds a requested row
    row_t        line_row;
    line_cnt_t   line_cnt;
    line_sx_t    line_sx;
    sum_s_t      acc_s;
    sum_sx_t     acc_sx;
    sum_sy_t     acc_sy;
    sum_s_t      acc_s_next;
    sum_sx_t     acc_sx_next;
    sum_sy_t     acc_sy_next;

    // Set-bit count and position sum of the returned line
    always_comb begin
        line_cnt = '0;
        line_sx  = '0;
        for (int x = 0; x < LINE_PIXELS; x++) begin
            if (rd_line[x]) begin
                line_cnt = line_cnt + 1'b1;
                line_sx  = line_sx + line_sx_t'(x);
            end
        end
    end

    assign acc_s_next  = line_valid ? acc_s + sum_s_t'(line_cnt) : acc_s;
    assign acc_sx_next = line_valid ? acc_sx + sum_sx_t'(line_sx) : acc_sx;
    assign acc_sy_next = line_valid ? acc_sy + sum_sy_t'(line_row) * sum_sy_t'(line_cnt)
                                    : acc_sy;

    // --------------------------------------------------
    // Read-out FSM
    // --------------------------------------------------
    always_ff @(posedge cclk) begin
        if (rst) begin
            state      <= GRAV_IDLE;
            rd_row     <= '0;
            line_valid <= 1'b0;
        end else begin
            line_valid <= (state == GRAV_READ);
            case (state)
                GRAV_IDLE: begin
                    if (frame_done && !report_busy) begin   // Frame dropped while busy
                        state  <= GRAV_READ;
                        rd_row <= '0;
                    end
                end
                GRAV_READ: begin
                    if (rd_row == row_t'(FRAME_LINES - 1)) state <= GRAV_ACCUM;
                    else                                   rd_row <= rd_row + 1'b1;
                end
                GRAV_ACCUM:  state <= GRAV_FINISH;  // Last line added here
                default:     state <= GRAV_IDLE;
            endcase
        end
    end

    always_ff @(posedge cclk) begin
        line_row <= rd_row;
        if (state == GRAV_IDLE) begin
            acc_s  <= '0;
            acc_sx <= '0;
            acc_sy <= '0;
        end else begin
            acc_s  <= acc_s_next;
            acc_sx <= acc_sx_next;
            acc_sy <= acc_sy_next;
        end
        if (state == GRAV_ACCUM) begin            // Results held until the next frame
            sum_s  <= acc_s_next;
            sum_sx <= acc_sx_next;
            sum_sy <= acc_sy_next;
        end
    end

    assign report_start = (state == GRAV_FINISH);

endmodule

/* source/report_pkg.sv */
/*
 * Report side definitions
 *   gravity sum widths, UART bit timing
 *   message layout and reporter FSM states
 */
package report_pkg;

    localparam int SUM_S_BITS   = 10;
    localparam int SUM_SX_BITS  = 14;
    localparam int SUM_SY_BITS  = 14;

    typedef logic [SUM_S_BITS-1:0]  sum_s_t;
    typedef logic [SUM_SX_BITS-1:0] sum_sx_t;
    typedef logic [SUM_SY_BITS-1:0] sum_sy_t;
    typedef logic [7:0]             byte_t;

    // 8N1 bit timing in cclk cycles
    localparam int CLKS_PER_BIT = 8;
    localparam int TICK_BITS    = $clog2(CLKS_PER_BIT);

    // Header followed by three 16-bit fields sent high byte first
    localparam byte_t MSG_HEADER   = 8'hA5;
    localparam int    MSG_BYTES    = 7;
    localparam int    MSG_IDX_BITS = $clog2(MSG_BYTES);
    localparam int    FIELD_BITS   = 16;

    typedef logic [FIELD_BITS-1:0] field_t;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage

/* source/uart_report.sv */
/*
 * UART reporter
 *   latches the gravity sums, sequences the 7-byte message
 *   and serializes it as 8N1
 */
module uart_report (
    input  logic                cclk,
    input  logic                rst,
    input  logic                report_start,
    input  report_pkg::sum_s_t  sum_s,
    input  report_pkg::sum_sx_t sum_sx,
    input  report_pkg::sum_sy_t sum_sy,
    output logic                report_busy,
    output logic                uart_txd
);
    import report_pkg::*;

    tx_state_t               state;
    logic [TICK_BITS-1:0]    tick;                  // Cycles within a bit
    logic [2:0]              bit_idx;
    logic [MSG_IDX_BITS-1:0] byte_idx;
    logic                    bit_end;
    field_t                  s_q;
    field_t                  sx_q;
    field_t                  sy_q;
    byte_t                   cur_byte;

    assign bit_end = (tick == TICK_BITS'(CLKS_PER_BIT - 1));

    // Sums held for the whole message
    always_ff @(posedge cclk) begin
        if (state == TX_IDLE && report_start) begin
            s_q  <= field_t'(sum_s);
            sx_q <= field_t'(sum_sx);
            sy_q <= field_t'(sum_sy);
        end
    end

    // --------------------------------------------------
    // Message byte select
    // --------------------------------------------------
    always_comb begin
        case (byte_idx)
            3'd1:    cur_byte = s_q[FIELD_BITS-1 -: 8];
            3'd2:    cur_byte = s_q[7:0];
            3'd3:    cur_byte = sx_q[FIELD_BITS-1 -: 8];
            3'd4:    cur_byte = sx_q[7:0];
            3'd5:    cur_byte = sy_q[FIELD_BITS-1 -: 8];
            3'd6:    cur_byte = sy_q[7:0];
            default: cur_byte = MSG_HEADER;
        endcase
    end

    // --------------------------------------------------
    // Serializer FSM
    // --------------------------------------------------
    always_ff @(posedge cclk) begin
        if (rst) begin
            state    <= TX_IDLE;
            tick     <= '0;
            bit_idx  <= '0;
            byte_idx <= '0;
        end else begin
            if (state != TX_IDLE) tick <= bit_end ? '0 : tick + 1'b1;
            case (state)
                TX_IDLE: begin
                    tick <= '0;
                    if (report_start) begin
                        state    <= TX_START;
                        byte_idx <= '0;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= TX_STOP;
                    end
                end
                default: begin                      // Stop bit
                    if (bit_end) begin
                        if (byte_idx == MSG_IDX_BITS'(MSG_BYTES - 1)) begin
                            state <= TX_IDLE;
                        end else begin
                            state    <= TX_START;   // Next byte without a gap
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // Line level from the FSM with data bits LSB first
    always_comb begin
        case (state)
            TX_START: uart_txd = 1'b0;
            TX_DATA:  uart_txd = cur_byte[bit_idx];
            default:  uart_txd = 1'b1;
        endcase
    end

    assign report_busy = (state != TX_IDLE);

endmodule

/* source/video_pkg.sv */
/*
 * Image side definitions of the eye tracker
 *   frame geometry, pixel and binary line types
 *   per-line count widths used by the gravity calculator
 *   capture and gravity FSM state encodings
 */
package video_pkg;

    // --------------------------------------------------
    // Geometry
    // --------------------------------------------------
    localparam int PIXEL_BITS    = 8;
    localparam int LINE_PIXELS   = 32;
    localparam int FRAME_LINES   = 16;
    localparam int X_BITS        = $clog2(LINE_PIXELS);
    localparam int ROW_BITS      = $clog2(FRAME_LINES);

    // Per-line results with up to 32 set bits and an x sum up to 496
    localparam int LINE_CNT_BITS = X_BITS + 1;
    localparam int LINE_SX_BITS  = 2 * X_BITS - 1;

    typedef logic [PIXEL_BITS-1:0]    pixel_t;
    typedef logic [LINE_PIXELS-1:0]   line_t;     // Bit x holds pixel x
    typedef logic [X_BITS-1:0]        x_t;
    typedef logic [ROW_BITS-1:0]      row_t;
    typedef logic [LINE_CNT_BITS-1:0] line_cnt_t;
    typedef logic [LINE_SX_BITS-1:0]  line_sx_t;

    // --------------------------------------------------
    // State encodings
    // --------------------------------------------------
    typedef enum logic [1:0] {
        CAP_IDLE,       // Waiting for fval
        CAP_FRAME,      // Lines being written
        CAP_FULL        // All lines stored, rest of frame ignored
    } cap_state_t;

    typedef enum logic [1:0] {
        GRAV_IDLE,
        GRAV_READ,
        GRAV_ACCUM,
        GRAV_FINISH
    } grav_state_t;

endpackage

/* verif/tb_eye_tracker.sv */
/*
 * Testbench for the eye tracker top level
 *   clock, reset, random frame stimulus with a reference model
 *   UART decoder and message checks
 */
module tb_eye_tracker;
    timeunit 1ns;
    timeprecision 1ps;

    import video_pkg::*;
    import report_pkg::*;

    localparam int CLK_HALF   = 10;
    localparam int MSG_CYCLES = MSG_BYTES * 10 * CLKS_PER_BIT;
    localparam int START_WAIT = 400;                // Frame end to first start bit
    localparam int BYTE_WAIT  = 2 * CLKS_PER_BIT;

    logic   cclk;
    logic   rst;
    logic   fval;
    logic   lval;
    logic   dval;
    pixel_t data;
    pixel_t threshold;
    logic   uart_txd;
    integer seed;

    // Model sums with one entry per frame sent
    sum_s_t  exp_s [$];
    sum_sx_t exp_sx [$];
    sum_sy_t exp_sy [$];
    byte_t   rx_msg [MSG_BYTES];                    // Last decoded message

    eye_tracker_top UUT (
        .cclk(cclk), .rst(rst),
        .fval(fval), .lval(lval), .dval(dval),
        .data(data), .threshold(threshold),
        .uart_txd(uart_txd)
    );

    initial begin
        cclk = 1'b0;
        forever #CLK_HALF cclk = ~cclk;
    end

    // --------------------------------------------------
    // Error handling and compare tasks
    // --------------------------------------------------
    task automatic stop_run();
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic fail_with(input string what);
        $display("%s", what);
        stop_run();
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_sums(input string name,
                              input sum_s_t exp_a, input sum_sx_t exp_x, input sum_sy_t exp_y,
                              input sum_s_t act_a, input sum_sx_t act_x, input sum_sy_t act_y);
        if (act_a !== exp_a || act_x !== exp_x || act_y !== exp_y) begin
            $display("Error %s: expected s=%0d sx=%0d sy=%0d, actual s=%0d sx=%0d sy=%0d",
                     name, exp_a, exp_x, exp_y, act_a, act_x, act_y);
            stop_run();
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // Header followed by each sum as 16 bits high byte first
    function automatic byte_t expected_byte(input int idx, input int k);
        logic [15:0] field;
        case (k)
            1, 2:    field = 16'(exp_s[idx]);
            3, 4:    field = 16'(exp_sx[idx]);
            default: field = 16'(exp_sy[idx]);
        endcase
        if (k == 0) return MSG_HEADER;
        return (k % 2 == 1) ? field[15:8] : field[7:0];
    endfunction

    // --------------------------------------------------
    // Frame stimulus and model
    // --------------------------------------------------
    task automatic send_frame(input pixel_t thr, input int pix_max, input int len_lo,
                              input int len_hi, input bit gaps, input bit strays);
        int     s;
        int     sx;
        int     sy;
        int     x;
        int     len;
        pixel_t pix;
        bit     keep;
        s  = 0;
        sx = 0;
        sy = 0;
        threshold = thr;
        if (strays) begin                           // Line pulse before the frame
            lval = 1'b1;
            dval = 1'b1;
            data = 8'hFF;
            repeat (rand_range(2, 5)) @(negedge cclk);
            lval = 1'b0;
            repeat (2) @(negedge cclk);
        end
        fval = 1'b1;
        for (int row = 0; row < FRAME_LINES; row++) begin
            repeat (rand_range(1, 3)) @(negedge cclk);
            len = rand_range(len_lo, len_hi);
            x   = 0;
            while (x < len) begin
                pix  = pixel_t'(rand_range(0, pix_max));
                keep = !gaps || (rand_range(0, 3) != 0);
                lval = 1'b1;
                dval = keep;
                data = pix;
                if (keep) begin
                    if (x < LINE_PIXELS && pix >= thr) begin
                        s  += 1;
                        sx += x;
                        sy += row;
                    end
                    x++;
                end
                @(negedge cclk);
            end
            lval = 1'b0;
            dval = 1'b0;
        end
        repeat (rand_range(1, 3)) @(negedge cclk);
        fval = 1'b0;
        exp_s.push_back(sum_s_t'(s));
        exp_sx.push_back(sum_sx_t'(sx));
        exp_sy.push_back(sum_sy_t'(sy));
        repeat (rand_range(2, 6)) @(negedge cclk);
    endtask

    // --------------------------------------------------
    // UART decoder with mid-bit sampling
    // --------------------------------------------------
    task automatic wait_start(input int limit, output bit seen);
        int n;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(negedge cclk);
            seen = (uart_txd == 1'b0);
            n++;
        end
    endtask

    task automatic read_byte(output byte_t b);
        repeat (CLKS_PER_BIT / 2) @(negedge cclk);
        if (uart_txd !== 1'b0) fail_with("Start bit on uart_txd did not last to mid-bit");
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge cclk);
            b[i] = uart_txd;                        // LSB first
        end
        repeat (CLKS_PER_BIT) @(negedge cclk);
        if (uart_txd !== 1'b1) fail_with("Stop bit missing on uart_txd");
    endtask

    // First start bit already found by the caller
    task automatic read_message();
        bit seen;
        read_byte(rx_msg[0]);
        for (int k = 1; k < MSG_BYTES; k++) begin
            wait_start(BYTE_WAIT, seen);
            if (!seen) fail_with($sformatf("Message broke off after %0d bytes", k));
            read_byte(rx_msg[k]);
        end
    endtask

    function automatic bit message_matches(input int idx);
        for (int k = 0; k < MSG_BYTES; k++) begin
            if (rx_msg[k] !== expected_byte(idx, k)) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic check_message(input string name, input int idx);
        check_sums(name, exp_s[idx], exp_sx[idx], exp_sy[idx],
                   sum_s_t'({rx_msg[1], rx_msg[2]}), sum_sx_t'({rx_msg[3], rx_msg[4]}),
                   sum_sy_t'({rx_msg[5], rx_msg[6]}));
        for (int k = 0; k < MSG_BYTES; k++) begin
            check_byte($sformatf("%s byte %0d", name, k), expected_byte(idx, k), rx_msg[k]);
        end
    endtask

    task automatic expect_message(input string name);
        bit seen;
        wait_start(START_WAIT, seen);
        if (!seen) fail_with($sformatf("No message started on uart_txd after %s", name));
        read_message();
        check_message(name, exp_s.size() - 1);
    endtask

    // Short frames back to back with messages as an ordered subsequence
    task automatic run_back_pressure();
        int first;
        int next;
        int received;
        bit seen;
        bit found;
        first    = exp_s.size();
        next     = first;
        received = 0;
        seen     = 1'b1;
        fork
            for (int f = 0; f < 6; f++) begin
                send_frame(pixel_t'(rand_range(0, 255)), 255, 8, 20, 1'b0, 1'b0);
            end
            while (seen) begin
                wait_start(MSG_CYCLES + 100, seen);   // Long idle ends the collection
                if (seen) begin
                    read_message();
                    found = 1'b0;
                    if (received == 0) begin
                        check_message("back-pressure first frame", first);
                        found = 1'b1;
                        next  = first + 1;
                    end
                    while (!found && next < exp_s.size()) begin
                        found = message_matches(next);
                        next++;
                    end
                    if (!found) fail_with("Back-pressure message matches no later frame");
                    received++;
                end
            end
        join
        if (received == 0) fail_with("No message received for the back-to-back frames");
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        seed      = 1211;
        rst       = 1'b1;
        fval      = 1'b0;
        lval      = 1'b0;
        dval      = 1'b0;
        data      = '0;
        threshold = '0;
        repeat (3) @(posedge cclk);
        @(negedge cclk);
        rst = 1'b0;

        for (int n = 0; n < 200; n++) begin
            @(negedge cclk);
            if (uart_txd !== 1'b1) fail_with("uart_txd left the idle level with no frame sent");
        end

        for (int f = 0; f < 10; f++) begin
            send_frame(pixel_t'(rand_range(0, 255)), 255, 28, 35, 1'b1, 1'b0);
            expect_message($sformatf("random frame %0d", f));
        end

        send_frame(8'd0, 255, 32, 35, 1'b1, 1'b0);       // Every counted pixel set
        expect_message("threshold 0");
        check_sums("threshold 0 totals", sum_s_t'(512), sum_sx_t'(7936), sum_sy_t'(3840),
                   sum_s_t'({rx_msg[1], rx_msg[2]}), sum_sx_t'({rx_msg[3], rx_msg[4]}),
                   sum_sy_t'({rx_msg[5], rx_msg[6]}));
        send_frame(8'd255, 254, 28, 35, 1'b1, 1'b0);
        expect_message("threshold 255");
        check_sums("threshold 255 totals", '0, '0, '0,
                   sum_s_t'({rx_msg[1], rx_msg[2]}), sum_sx_t'({rx_msg[3], rx_msg[4]}),
                   sum_sy_t'({rx_msg[5], rx_msg[6]}));

        for (int f = 0; f < 3; f++) begin
            send_frame(pixel_t'(rand_range(0, 255)), 255, 30, 36, 1'b1, 1'b1);
            expect_message($sformatf("ignored pixels %0d", f));
        end

        run_back_pressure();

        $display("All tests passed!");
        $finish;
    end

endmodule
